/* design/trace_pkg.sv */
/*
  Shared definitions for the retirement trace subsystem.
  Holds the trace entry layout, the RV32I opcodes the core decodes,
  the host register map and the AXI response codes.
  Other files refer to these by scoped names.
*/
`default_nettype none

package trace_pkg;

  localparam int XLEN        = 32;
  localparam int ORDER_W     = 64;
  localparam int TRACE_DEPTH = 8;
  localparam int PTR_W       = $clog2(TRACE_DEPTH);
  localparam int FILL_W      = PTR_W + 1;

  // word 3 (meta) holds order[15:0] in 31:16, trap in 8, rd in 4:0
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] meta;
  } trace_entry_t;

  // major opcodes and function fields
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  // host register map, byte offsets
  localparam logic [XLEN-1:0] REG_STATUS  = 32'h00;
  localparam logic [XLEN-1:0] REG_DROPPED = 32'h04;
  localparam logic [XLEN-1:0] REG_RETIRED = 32'h08;
  localparam logic [XLEN-1:0] REG_CTRL    = 32'h0C;
  localparam logic [XLEN-1:0] REG_ENTRY0  = 32'h10;
  localparam logic [XLEN-1:0] REG_ENTRY1  = 32'h14;
  localparam logic [XLEN-1:0] REG_ENTRY2  = 32'h18;
  localparam logic [XLEN-1:0] REG_ENTRY3  = 32'h1C;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* design/rvfi_if.sv */
/*
  Retirement record bundle between the core and the tracer.
  The core drives it through the core modport, the tracer samples it
  through the tracer modport. rvfi_valid pulses once per retirement.
*/
`default_nettype none

interface rvfi_if;
  logic                          rvfi_valid;
  logic [trace_pkg::ORDER_W-1:0] rvfi_order;
  logic [trace_pkg::XLEN-1:0]    rvfi_insn;
  logic                          rvfi_trap;
  logic [4:0]                    rvfi_rd_addr;
  logic [trace_pkg::XLEN-1:0]    rvfi_rd_wdata;
  logic [trace_pkg::XLEN-1:0]    rvfi_pc_rdata;

  modport core (
    output rvfi_valid, rvfi_order, rvfi_insn, rvfi_trap,
    output rvfi_rd_addr, rvfi_rd_wdata, rvfi_pc_rdata
  );

  modport tracer (
    input rvfi_valid, rvfi_order, rvfi_insn, rvfi_trap,
    input rvfi_rd_addr, rvfi_rd_wdata, rvfi_pc_rdata
  );
endinterface

`default_nettype wire

/* design/mini_core.sv */
/*
  Minimal in-order RV32I core that runs LUI, ADDI, XORI, ADD and SUB.
  Fetches one instruction at a time over a req/gnt/rvalid port,
  executes it and reports one retirement record per instruction.
  Unknown encodings retire with the trap flag set and no writeback.
*/
`default_nettype none

module mini_core (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       fetch_enable_i,
  input  logic [trace_pkg::XLEN-1:0] boot_addr_i,
  output logic                       instr_req_o,
  output logic [trace_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [trace_pkg::XLEN-1:0] instr_rdata_i,
  rvfi_if.core                       rvfi
);

  typedef enum logic [1:0] {S_FETCH, S_WAIT, S_RETIRE} state_e;

  state_e                        state_q;
  logic                          req_q;
  logic [trace_pkg::XLEN-1:0]    pc_q;
  logic [trace_pkg::ORDER_W-1:0] order_q;
  logic [trace_pkg::XLEN-1:0]    rf_q [32];

  logic [6:0]                 opcode;
  logic [4:0]                 rd;
  logic [4:0]                 rs1;
  logic [4:0]                 rs2;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [trace_pkg::XLEN-1:0] rs1_val;
  logic [trace_pkg::XLEN-1:0] rs2_val;
  logic [trace_pkg::XLEN-1:0] imm_i;
  logic [trace_pkg::XLEN-1:0] imm_u;
  logic [trace_pkg::XLEN-1:0] result;
  logic                       legal;
  logic                       retire_en;

  // decode straight from the fetch data so results land on the rvalid edge
  assign opcode  = instr_rdata_i[6:0];
  assign rd      = instr_rdata_i[11:7];
  assign funct3  = instr_rdata_i[14:12];
  assign rs1     = instr_rdata_i[19:15];
  assign rs2     = instr_rdata_i[24:20];
  assign funct7  = instr_rdata_i[31:25];
  assign imm_i   = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_u   = {instr_rdata_i[31:12], 12'b0};
  // x0 reads as zero, its storage is never written
  assign rs1_val = (rs1 == 5'd0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : rf_q[rs2];

  always_comb begin
    legal  = 1'b0;
    result = '0;
    case (opcode)
      trace_pkg::OPC_LUI: begin
        legal  = 1'b1;
        result = imm_u;
      end
      trace_pkg::OPC_OP_IMM: begin
        if (funct3 == trace_pkg::F3_ADD) begin
          legal  = 1'b1;
          result = rs1_val + imm_i;
        end else if (funct3 == trace_pkg::F3_XOR) begin
          legal  = 1'b1;
          result = rs1_val ^ imm_i;
        end
      end
      trace_pkg::OPC_OP: begin
        if (funct3 == trace_pkg::F3_ADD && funct7 == trace_pkg::F7_BASE) begin
          legal  = 1'b1;
          result = rs1_val + rs2_val;
        end else if (funct3 == trace_pkg::F3_ADD && funct7 == trace_pkg::F7_SUB) begin
          legal  = 1'b1;
          result = rs1_val - rs2_val;
        end
      end
      default: ;
    endcase
  end

  assign retire_en = (state_q == S_WAIT) && instr_rvalid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_FETCH;
      req_q   <= 1'b0;
      pc_q    <= boot_addr_i;
      order_q <= '0;
    end else begin
      case (state_q)
        S_FETCH: begin
          // once raised, the request stays up until granted
          if (req_q && instr_gnt_i) begin
            req_q   <= 1'b0;
            state_q <= S_WAIT;
          end else if (fetch_enable_i) begin
            req_q <= 1'b1;
          end
        end
        S_WAIT: begin
          if (instr_rvalid_i) begin
            pc_q    <= pc_q + 32'd4;
            state_q <= S_RETIRE;
          end
        end
        default: begin
          order_q <= order_q + 1'b1;
          req_q   <= fetch_enable_i;
          state_q <= S_FETCH;
        end
      endcase
    end
  end

  // writeback and retirement record
  always_ff @(posedge clk_i) begin
    if (retire_en) begin
      rvfi.rvfi_insn     <= instr_rdata_i;
      rvfi.rvfi_trap     <= !legal;
      rvfi.rvfi_rd_addr  <= legal ? rd : 5'd0;
      rvfi.rvfi_rd_wdata <= (legal && rd != 5'd0) ? result : '0;
      rvfi.rvfi_pc_rdata <= pc_q;
      if (legal && rd != 5'd0) begin
        rf_q[rd] <= result;
      end
    end
  end

  assign instr_req_o     = req_q;
  assign instr_addr_o    = pc_q;
  assign rvfi.rvfi_valid = (state_q == S_RETIRE);
  assign rvfi.rvfi_order = order_q;

endmodule

`default_nettype wire

/* design/rvfi_tracer.sv */
/*
  Retirement tracer.
  Packs every retirement record into a trace entry and stores it in a
  circular buffer of TRACE_DEPTH entries. Never stalls the core: when
  the buffer is full the entry is dropped and counted instead.
*/
`default_nettype none

module rvfi_tracer (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  rvfi_if.tracer                       rvfi,
  input  logic                         trace_en_i,
  input  logic                         pop_i,
  output trace_pkg::trace_entry_t      head_o,
  output logic [trace_pkg::FILL_W-1:0] fill_o,
  output logic [trace_pkg::XLEN-1:0]   dropped_o,
  output logic [trace_pkg::XLEN-1:0]   retired_o
);

  trace_pkg::trace_entry_t        entries_q [trace_pkg::TRACE_DEPTH];
  trace_pkg::trace_entry_t        entry;
  logic [trace_pkg::PTR_W-1:0]    wr_ptr_q;
  logic [trace_pkg::PTR_W-1:0]    rd_ptr_q;
  logic [trace_pkg::FILL_W-1:0]   count_q;
  logic                           full;
  logic                           empty;
  logic                           push;
  logic                           drop;
  logic                           pop;

  assign entry.pc       = rvfi.rvfi_pc_rdata;
  assign entry.insn     = rvfi.rvfi_insn;
  assign entry.rd_wdata = rvfi.rvfi_rd_wdata;
  assign entry.meta     = {rvfi.rvfi_order[15:0], 7'b0, rvfi.rvfi_trap, 3'b0,
                           rvfi.rvfi_rd_addr};

  assign full  = (32'(count_q) == trace_pkg::TRACE_DEPTH);
  assign empty = (count_q == '0);
  // disabled tracing neither stores nor drops
  assign push  = rvfi.rvfi_valid && trace_en_i && !full;
  assign drop  = rvfi.rvfi_valid && trace_en_i && full;
  assign pop   = pop_i && !empty;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      dropped_o <= '0;
      retired_o <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      if (rvfi.rvfi_valid) begin
        retired_o <= retired_o + 1'b1;
      end
      if (drop) begin
        dropped_o <= dropped_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries_q[wr_ptr_q] <= entry;
    end
  end

  assign head_o = entries_q[rd_ptr_q];
  assign fill_o = count_q;

endmodule

`default_nettype wire

/* design/trace_axil_slave.sv */
/*
  AXI4-Lite register slave for the trace buffer.
  Exposes fill level, counters, the trace enable bit and the four words
  of the head entry. Reading the last entry word pops the head entry
  once the R handshake completes. One transaction per channel at a time.
*/
`default_nettype none

module trace_axil_slave (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         s_awvalid_i,
  input  logic [trace_pkg::XLEN-1:0]   s_awaddr_i,
  input  logic                         s_wvalid_i,
  input  logic [trace_pkg::XLEN-1:0]   s_wdata_i,
  input  logic                         s_bready_i,
  input  logic                         s_arvalid_i,
  input  logic [trace_pkg::XLEN-1:0]   s_araddr_i,
  input  logic                         s_rready_i,
  output logic                         s_awready_o,
  output logic                         s_wready_o,
  output logic                         s_bvalid_o,
  output logic [1:0]                   s_bresp_o,
  output logic                         s_arready_o,
  output logic                         s_rvalid_o,
  output logic [trace_pkg::XLEN-1:0]   s_rdata_o,
  output logic [1:0]                   s_rresp_o,
  input  trace_pkg::trace_entry_t      head_i,
  input  logic [trace_pkg::FILL_W-1:0] fill_i,
  input  logic [trace_pkg::XLEN-1:0]   dropped_i,
  input  logic [trace_pkg::XLEN-1:0]   retired_i,
  output logic                         trace_en_o,
  output logic                         pop_o
);

  logic                       wr_en_q;
  logic                       wr_hs;
  logic                       rd_hs;
  logic                       pop_pend_q;
  logic                       empty;
  logic [trace_pkg::XLEN-1:0] rd_data;
  logic [1:0]                 rd_resp;

  // AW and W are taken in the same cycle
  assign s_awready_o = wr_en_q && s_wvalid_i;
  assign s_wready_o  = wr_en_q && s_awvalid_i;
  assign wr_hs       = wr_en_q && s_awvalid_i && s_wvalid_i;
  assign rd_hs       = s_arready_o && s_arvalid_i;
  assign empty       = (fill_i == '0);

  always_comb begin
    rd_data = '0;
    rd_resp = trace_pkg::RESP_OKAY;
    case (s_araddr_i)
      trace_pkg::REG_STATUS:  rd_data[trace_pkg::FILL_W-1:0] = fill_i;
      trace_pkg::REG_DROPPED: rd_data = dropped_i;
      trace_pkg::REG_RETIRED: rd_data = retired_i;
      trace_pkg::REG_CTRL:    rd_data[0] = trace_en_o;
      // entry words read as zero while the buffer is empty
      trace_pkg::REG_ENTRY0:  rd_data = empty ? '0 : head_i.pc;
      trace_pkg::REG_ENTRY1:  rd_data = empty ? '0 : head_i.insn;
      trace_pkg::REG_ENTRY2:  rd_data = empty ? '0 : head_i.rd_wdata;
      trace_pkg::REG_ENTRY3:  rd_data = empty ? '0 : head_i.meta;
      default:                rd_resp = trace_pkg::RESP_SLVERR;
    endcase
  end

  // write channel, readiness returns once the response is taken
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_en_q    <= 1'b0;
      s_bvalid_o <= 1'b0;
      trace_en_o <= 1'b1;
    end else if (wr_hs) begin
      wr_en_q    <= 1'b0;
      s_bvalid_o <= 1'b1;
      if (s_awaddr_i == trace_pkg::REG_CTRL) begin
        trace_en_o <= s_wdata_i[0];
      end
    end else if (s_bvalid_o && s_bready_i) begin
      s_bvalid_o <= 1'b0;
      wr_en_q    <= 1'b1;
    end else if (!s_bvalid_o) begin
      wr_en_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      s_bresp_o <= (s_awaddr_i == trace_pkg::REG_CTRL) ? trace_pkg::RESP_OKAY
                                                       : trace_pkg::RESP_SLVERR;
    end
  end

  // read channel
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
      pop_pend_q  <= 1'b0;
    end else if (rd_hs) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b1;
      pop_pend_q  <= (s_araddr_i == trace_pkg::REG_ENTRY3);
    end else if (s_rvalid_o && s_rready_i) begin
      s_rvalid_o  <= 1'b0;
      s_arready_o <= 1'b1;
      pop_pend_q  <= 1'b0;
    end else if (!s_rvalid_o) begin
      s_arready_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_resp;
    end
  end

  assign pop_o = s_rvalid_o && s_rready_i && pop_pend_q;

endmodule

`default_nettype wire

/* design/core_top_tracing.sv */
/*
  Top level of the core with its retirement tracer and host slave.
  Exposes the instruction fetch port and the AXI4-Lite host port.
*/
`default_nettype none

module core_top_tracing (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       fetch_enable_i,
  input  logic [trace_pkg::XLEN-1:0] boot_addr_i,
  output logic                       instr_req_o,
  output logic [trace_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [trace_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       s_awvalid_i,
  input  logic [trace_pkg::XLEN-1:0] s_awaddr_i,
  input  logic                       s_wvalid_i,
  input  logic [trace_pkg::XLEN-1:0] s_wdata_i,
  input  logic                       s_bready_i,
  input  logic                       s_arvalid_i,
  input  logic [trace_pkg::XLEN-1:0] s_araddr_i,
  input  logic                       s_rready_i,
  output logic                       s_awready_o,
  output logic                       s_wready_o,
  output logic                       s_bvalid_o,
  output logic [1:0]                 s_bresp_o,
  output logic                       s_arready_o,
  output logic                       s_rvalid_o,
  output logic [trace_pkg::XLEN-1:0] s_rdata_o,
  output logic [1:0]                 s_rresp_o
);

  trace_pkg::trace_entry_t        head;
  logic [trace_pkg::FILL_W-1:0]   fill;
  logic [trace_pkg::XLEN-1:0]     dropped;
  logic [trace_pkg::XLEN-1:0]     retired;
  logic                           trace_en;
  logic                           pop;

  rvfi_if rvfi ();

  mini_core u_core (
    .clk_i,
    .arst_n_i,
    .fetch_enable_i,
    .boot_addr_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_gnt_i,
    .instr_rvalid_i,
    .instr_rdata_i,
    .rvfi (rvfi.core)
  );

  rvfi_tracer u_tracer (
    .clk_i,
    .arst_n_i,
    .rvfi       (rvfi.tracer),
    .trace_en_i (trace_en),
    .pop_i      (pop),
    .head_o     (head),
    .fill_o     (fill),
    .dropped_o  (dropped),
    .retired_o  (retired)
  );

  trace_axil_slave u_axil (
    .clk_i,
    .arst_n_i,
    .s_awvalid_i,
    .s_awaddr_i,
    .s_wvalid_i,
    .s_wdata_i,
    .s_bready_i,
    .s_arvalid_i,
    .s_araddr_i,
    .s_rready_i,
    .s_awready_o,
    .s_wready_o,
    .s_bvalid_o,
    .s_bresp_o,
    .s_arready_o,
    .s_rvalid_o,
    .s_rdata_o,
    .s_rresp_o,
    .head_i     (head),
    .fill_i     (fill),
    .dropped_i  (dropped),
    .retired_i  (retired),
    .trace_en_o (trace_en),
    .pop_o      (pop)
  );

endmodule

`default_nettype wire

/* tb/tb_top.sv */
/*
  Testbench for the tracing core top level.
  Models the instruction memory with random grant and rvalid delays,
  reads trace entries and counters back over AXI4-Lite and compares
  them with tb/trace_golden.txt. Run from the project root.
*/
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] BOOT_ADDR       = 32'h0000_0080;
  localparam logic [31:0] NOP_INSN        = 32'h0000_0013;
  localparam int          DRIVE_DELAY     = 2;
  localparam int          CNT_BASE        = 84;
  localparam int          CYCLES_PER_INSN = 200;
  localparam int          TIMEOUT_MARGIN  = 1000;
  localparam int          DEPTH           = trace_pkg::TRACE_DEPTH;

  logic        clk_i;
  logic        arst_n_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        s_awvalid_i;
  logic [31:0] s_awaddr_i;
  logic        s_wvalid_i;
  logic [31:0] s_wdata_i;
  logic        s_bready_i;
  logic        s_arvalid_i;
  logic [31:0] s_araddr_i;
  logic        s_rready_i;
  logic        s_awready_o;
  logic        s_wready_o;
  logic        s_bvalid_o;
  logic [1:0]  s_bresp_o;
  logic        s_arready_o;
  logic        s_rvalid_o;
  logic [31:0] s_rdata_o;
  logic [1:0]  s_rresp_o;

  // golden image: 4 words per instruction, counter block at CNT_BASE
  logic [31:0] golden [0:127];
  logic [31:0] popped [DEPTH][4];
  logic [31:0] rng_state;
  int          n_instr;
  int          run_target;
  int          fetch_count;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;

  core_top_tracing u_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // linear congruential generator for the memory delays
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {16'b0, rng_state[31:16]};
  endfunction

  // instruction memory, one outstanding fetch, program word from the golden image
  initial begin : instr_mem
    int delay;
    int idx;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    fetch_enable_i = 1'b0;
    fetch_count    = 0;
    rng_state      = 32'd11;
    forever begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (!instr_req_o) begin
        fetch_enable_i = (fetch_count < run_target);
      end else begin
        delay = int'(next_rand() % 32'd4);
        repeat (delay) begin
          @(posedge clk_i);
          #DRIVE_DELAY;
        end
        // request and sequential address must hold until the grant
        compare("fetch request held", {31'b0, instr_req_o}, 32'h1);
        compare("fetch address", instr_addr_o, BOOT_ADDR + 32'(4 * fetch_count));
        idx = int'((instr_addr_o - BOOT_ADDR) >> 2);
        instr_gnt_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_gnt_i = 1'b0;
        delay = 1 + int'(next_rand() % 32'd3);
        repeat (delay - 1) begin
          @(posedge clk_i);
          #DRIVE_DELAY;
        end
        instr_rdata_i  = (idx < n_instr) ? golden[4 * idx + 1] : NOP_INSN;
        instr_rvalid_i = 1'b1;
        fetch_count    = fetch_count + 1;
        // stop the core after the last fetch of this run
        fetch_enable_i = (fetch_count < run_target);
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    int limit;
    cycles = 0;
    @(posedge clk_i);
    limit = CYCLES_PER_INSN * n_instr + TIMEOUT_MARGIN;
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    $display("timeout: the run did not finish within %0d clock cycles", limit);
    $display("TB FAILED");
    $finish;
  end

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("[FAIL] t=%0d ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - test_err_start;
    tests_run = tests_run + 1;
    if (n != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("test %-20s %s (%0d mismatches)", name, (n == 0) ? "ok" : "failed", n);
  endtask

  // AXI4-Lite accesses start and end 2 ns after a rising edge
  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    s_rready_i  = 1'b1;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_arvalid_i = 1'b0;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_rready_i = 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_bready_i  = 1'b1;
    @(negedge clk_i);
    while (!s_awready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    @(posedge clk_i);
    #DRIVE_DELAY;
    s_bready_i = 1'b0;
  endtask

  task automatic expect_reg(input string what, input logic [31:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    compare(what, data, exp);
    compare({what, " resp"}, {30'b0, resp}, {30'b0, trace_pkg::RESP_OKAY});
  endtask

  task automatic run_instrs(input int n);
    @(negedge clk_i);
    run_target = run_target + n;
    while (fetch_count < run_target) @(negedge clk_i);
    // last retirement reaches the tracer two edges after its rvalid
    repeat (3) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  // reading entry word 3 pops the head entry
  task automatic pop_entries(input int n);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < n; i++) begin
      for (int w = 0; w < 4; w++) begin
        read_reg(trace_pkg::REG_ENTRY0 + 32'(4 * w), data, resp);
        popped[i][w] = data;
        compare("entry read resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_OKAY});
      end
    end
  endtask

  task automatic compare_entry(input int slot, input int order);
    for (int w = 0; w < 4; w++) begin
      compare($sformatf("order %0d word %0d", order, w), popped[slot][w],
              golden[4 * order + w]);
    end
  endtask

  // order numbers count retirements from 0, one step per instruction
  task automatic check_order_numbers(input int first, input int n);
    for (int i = 0; i < n; i++) begin
      compare("order number", {16'b0, popped[i][3][31:16]}, {16'b0, 16'(first + i)});
    end
  endtask

  task automatic alu_program_trace();
    begin_test();
    run_instrs(DEPTH);
    expect_reg("fill after alu program", trace_pkg::REG_STATUS, 32'(DEPTH));
    pop_entries(DEPTH);
    for (int i = 0; i < 5; i++) begin
      compare_entry(i, i);
    end
    check_order_numbers(0, DEPTH);
    end_test("alu_program");
  endtask

  task automatic x0_handling();
    begin_test();
    compare("x0 write rd", {27'b0, popped[5][3][4:0]}, 32'h0);
    compare("x0 write wdata", popped[5][2], 32'h0);
    compare_entry(5, 5);
    // order 7 reads x0 as a source
    compare_entry(7, 7);
    end_test("x0_handling");
  endtask

  task automatic illegal_insn_trap();
    begin_test();
    compare("trap bit", {31'b0, popped[6][3][8]}, 32'h1);
    compare("trap rd", {27'b0, popped[6][3][4:0]}, 32'h0);
    compare("trap wdata", popped[6][2], 32'h0);
    compare_entry(6, 6);
    compare_entry(7, 7);
    end_test("illegal_insn_trap");
  endtask

  task automatic disabled_tracing();
    logic [1:0]  resp;
    int          n_run;
    begin_test();
    n_run = int'(golden[CNT_BASE + 1]) - DEPTH;
    // the buffer was drained and DEPTH instructions have retired
    expect_reg("fill before", trace_pkg::REG_STATUS, 32'h0);
    expect_reg("retired before", trace_pkg::REG_RETIRED, 32'(DEPTH));
    write_reg(trace_pkg::REG_CTRL, 32'h0, resp);
    compare("ctrl write resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_OKAY});
    expect_reg("trace enable", trace_pkg::REG_CTRL, 32'h0);
    run_instrs(n_run);
    expect_reg("retired golden", trace_pkg::REG_RETIRED, golden[CNT_BASE + 1]);
    expect_reg("fill unchanged", trace_pkg::REG_STATUS, 32'h0);
    write_reg(trace_pkg::REG_CTRL, 32'h1, resp);
    compare("ctrl write resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_OKAY});
    end_test("disabled_tracing");
  endtask

  task automatic buffer_overflow();
    int n_run;
    int first;
    begin_test();
    first = int'(golden[CNT_BASE + 1]);
    n_run = n_instr - first;
    run_instrs(n_run);
    expect_reg("fill when full", trace_pkg::REG_STATUS, 32'(DEPTH));
    expect_reg("dropped by rule", trace_pkg::REG_DROPPED, 32'(n_run - DEPTH));
    expect_reg("dropped golden", trace_pkg::REG_DROPPED, golden[CNT_BASE + 3]);
    expect_reg("retired golden", trace_pkg::REG_RETIRED, golden[CNT_BASE + 2]);
    pop_entries(DEPTH);
    // oldest entries come out first
    for (int i = 0; i < DEPTH; i++) begin
      compare_entry(i, first + i);
    end
    check_order_numbers(first, DEPTH);
    expect_reg("fill after pops", trace_pkg::REG_STATUS, 32'h0);
    end_test("buffer_overflow");
  endtask

  task automatic bus_error_responses();
    logic [31:0] data;
    logic [1:0]  resp;
    begin_test();
    read_reg(32'h20, data, resp);
    compare("unmapped read data", data, 32'h0);
    compare("unmapped read resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_SLVERR});
    write_reg(32'h20, 32'h1, resp);
    compare("unmapped write resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_SLVERR});
    write_reg(trace_pkg::REG_DROPPED, 32'h0000_ffff, resp);
    compare("read-only write resp", {30'b0, resp}, {30'b0, trace_pkg::RESP_SLVERR});
    expect_reg("dropped kept", trace_pkg::REG_DROPPED, golden[CNT_BASE + 3]);
    for (int w = 0; w < 4; w++) begin
      expect_reg($sformatf("empty entry word %0d", w),
                 trace_pkg::REG_ENTRY0 + 32'(4 * w), 32'h0);
    end
    // the word 3 read above must not pop an empty buffer
    expect_reg("fill still empty", trace_pkg::REG_STATUS, 32'h0);
    end_test("bus_errors");
  endtask

  initial begin : main
    arst_n_i       = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    s_awvalid_i    = 1'b0;
    s_awaddr_i     = '0;
    s_wvalid_i     = 1'b0;
    s_wdata_i      = '0;
    s_bready_i     = 1'b0;
    s_arvalid_i    = 1'b0;
    s_araddr_i     = '0;
    s_rready_i     = 1'b0;
    run_target     = 0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    $readmemh("tb/trace_golden.txt", golden);
    n_instr = int'(golden[CNT_BASE]);
    repeat (4) @(posedge clk_i);
    #DRIVE_DELAY;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    alu_program_trace();
    x0_handling();
    illegal_insn_trap();
    disabled_tracing();
    buffer_overflow();
    bus_error_responses();
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (tests_failed == 0 && errors == 0 && n_instr > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/trace_golden.txt */
// columns: pc insn rd_wdata meta, one line per instruction in retirement order
// insn doubles as the program word at pc; meta = order[15:0], trap in bit 8, rd
// block at @54: instruction count, retired after disabled run, final retired, dropped
@00
00000080 123450B7 12345000 00000001 // lui  x1, 0x12345
00000084 67808113 12345678 00010002 // addi x2, x1, 0x678
00000088 FFF14193 EDCBA987 00020003 // xori x3, x2, -1
0000008C 00310233 FFFFFFFF 00030004 // add  x4, x2, x3
00000090 401202B3 EDCBAFFF 00040005 // sub  x5, x4, x1
00000094 00510013 00000000 00050000 // addi x0, x2, 5
00000098 0000A303 00000000 00060100 // lw   x6, 0(x1), unsupported
0000009C 00500333 EDCBAFFF 00070006 // add  x6, x0, x5
000000A0 00100393 00000001 00080007 // addi x7, x0, 1, tracing off
000000A4 00138393 00000002 00090007 // addi x7, x7, 1, tracing off
000000A8 00138393 00000003 000A0007 // addi x7, x7, 1, tracing off
000000AC 00738433 00000006 000B0008 // add  x8, x7, x7
000000B0 407404B3 00000003 000C0009 // sub  x9, x8, x7
000000B4 0F04C513 000000F3 000D000A // xori x10, x9, 0x0f0
000000B8 FFFFF5B7 FFFFF000 000E000B // lui  x11, 0xfffff
000000BC FFF58613 FFFFEFFF 000F000C // addi x12, x11, -1
000000C0 00A606B3 FFFFF0F2 0010000D // add  x13, x12, x10
000000C4 40900733 FFFFFFFD 0011000E // sub  x14, x0, x9
000000C8 7FF74793 FFFFF802 0012000F // xori x15, x14, 0x7ff
000000CC 00D780B3 FFFFE8F4 00130001 // add  x1, x15, x13, dropped
000000D0 01008113 FFFFE904 00140002 // addi x2, x1, 0x10, dropped
@54
00000015 0000000B 00000015 00000002

/* tb.f */
design/trace_pkg.sv
design/rvfi_if.sv
design/mini_core.sv
design/rvfi_tracer.sv
design/trace_axil_slave.sv
design/core_top_tracing.sv
tb/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
